//--- rtl/life_params.svh
`ifndef LIFE_PARAMS_SVH
`define LIFE_PARAMS_SVH

// board geometry
`define GRID_COLS 40
`define GRID_ROWS 30

// generation counter runs 0 .. GEN_MODULUS-1
`define GEN_MODULUS 100

`endif

//--- rtl/life_pkg.sv
`default_nettype none

`include "life_params.svh"

package life_pkg;

	// bit c is column c
	typedef logic [`GRID_COLS-1:0] row_t;

	// row r sits at bits r*GRID_COLS +: GRID_COLS
	typedef logic [`GRID_ROWS*`GRID_COLS-1:0] board_t;

	typedef logic [$clog2(`GRID_COLS)-1:0] col_idx_t;
	typedef logic [$clog2(`GRID_ROWS)-1:0] row_idx_t;

	typedef logic [$clog2(`GRID_COLS+1)-1:0] row_pop_t;              // 0 .. 40
	typedef logic [$clog2(`GRID_ROWS*`GRID_COLS+1)-1:0] pop_t;       // 0 .. 1200

	typedef logic [$clog2(`GEN_MODULUS)-1:0] gen_t;

endpackage

`default_nettype wire

//--- rtl/row_if.sv
`default_nettype none

// one board row with its two vertical neighbours, plus what the rule makes of it
interface row_if;

	life_pkg::row_t above;
	life_pkg::row_t middle;
	life_pkg::row_t below;

	life_pkg::row_t next_row;
	life_pkg::row_pop_t live;     // live cells in middle

	modport store (output above, output middle, output below, input next_row);

	modport rule (
		input above,
		input middle,
		input below,
		output next_row,
		output live
	);

	modport count (input live);

endinterface

`default_nettype wire

//--- rtl/board_store.sv
`default_nettype none

`include "life_params.svh"

module board_store (
	input wire logic clock,
	input wire logic resetn,

	input wire logic step,
	input wire logic edit,
	input wire logic save,
	input wire logic restore,

	input wire life_pkg::col_idx_t x,
	input wire life_pkg::row_idx_t y,

	row_if.store rows [0:`GRID_ROWS-1],

	output life_pkg::board_t board,
	output life_pkg::gen_t generation
);

	localparam int CELLS = `GRID_ROWS * `GRID_COLS;
	localparam int IDX_W = $clog2(CELLS);

	// dead cells beyond the top and bottom edges
	localparam life_pkg::row_t EMPTY_ROW = '0;

	life_pkg::board_t cur_board;
	life_pkg::board_t saved_board;
	life_pkg::board_t next_board;

	life_pkg::gen_t gen;
	life_pkg::gen_t gen_next;

	logic edit_ok;
	logic [IDX_W-1:0] cell_idx;

	// slice the board into neighbourhoods, collect the next rows back
	for (genvar r = 0; r < `GRID_ROWS; r++)
	begin : g_rows
		assign rows[r].middle = cur_board[r*`GRID_COLS +: `GRID_COLS];

		if (r == 0)
		begin : g_top
			assign rows[r].above = EMPTY_ROW;
		end
		else
		begin : g_inner_top
			assign rows[r].above = cur_board[(r-1)*`GRID_COLS +: `GRID_COLS];
		end

		if (r == `GRID_ROWS-1)
		begin : g_bottom
			assign rows[r].below = EMPTY_ROW;
		end
		else
		begin : g_inner_bottom
			assign rows[r].below = cur_board[(r+1)*`GRID_COLS +: `GRID_COLS];
		end

		assign next_board[r*`GRID_COLS +: `GRID_COLS] = rows[r].next_row;
	end

	// edits off the board are dropped
	assign edit_ok = (x < `GRID_COLS) && (y < `GRID_ROWS);
	assign cell_idx = IDX_W'(y) * IDX_W'(`GRID_COLS) + IDX_W'(x);

	assign gen_next = (gen == life_pkg::gen_t'(`GEN_MODULUS-1)) ? '0 : gen + 1'b1;

	// restore > step > edit > save, only one acts per edge
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			cur_board <= '0;
			saved_board <= '0;
			gen <= '0;
		end
		else if (restore)
		begin
			cur_board <= saved_board;     // generation kept
		end
		else if (step)
		begin
			cur_board <= next_board;
			gen <= gen_next;
		end
		else if (edit)
		begin
			if (edit_ok)
			begin
				cur_board[cell_idx] <= ~cur_board[cell_idx];
			end
		end
		else if (save)
		begin
			saved_board <= cur_board;
		end
	end

	assign board = cur_board;
	assign generation = gen;

	a_gen_range: assert property (
		@(posedge clock) disable iff (!resetn)
		gen < life_pkg::gen_t'(`GEN_MODULUS)
	) else $error("generation out of range: %0d", gen);

	// a step that is not overridden by restore must move the counter
	a_step_advances: assert property (
		@(posedge clock) disable iff (!resetn)
		(step && !restore) |=> (gen != $past(gen))
	) else $error("step did not advance generation");

endmodule

`default_nettype wire

//--- rtl/row_rule.sv
`default_nettype none

`include "life_params.svh"

module row_rule (
	row_if.rule rows
);

	// rows padded with a dead cell on each side
	logic [`GRID_COLS+1:0] up_pad;
	logic [`GRID_COLS+1:0] mid_pad;
	logic [`GRID_COLS+1:0] dn_pad;

	logic [3:0] nbr [`GRID_COLS];
	life_pkg::row_t next_cells;
	life_pkg::row_pop_t live_cnt;

	function automatic logic [3:0] ones8(input logic [7:0] v);
		logic [3:0] s;
		s = '0;
		for (int i = 0; i < 8; i++)
		begin
			s = s + 4'(v[i]);
		end
		return s;
	endfunction

	assign up_pad = {1'b0, rows.above, 1'b0};
	assign mid_pad = {1'b0, rows.middle, 1'b0};
	assign dn_pad = {1'b0, rows.below, 1'b0};

	// padded bit c+1 is column c
	for (genvar c = 0; c < `GRID_COLS; c++)
	begin : g_cols
		assign nbr[c] = ones8({
			up_pad[c+2:c],
			mid_pad[c+2],
			mid_pad[c],
			dn_pad[c+2:c]
		});

		// birth on 3, survival on 2 or 3
		assign next_cells[c] = (nbr[c] == 4'd3) || ((nbr[c] == 4'd2) && mid_pad[c+1]);
	end

	always_comb
	begin
		live_cnt = '0;
		for (int c = 0; c < `GRID_COLS; c++)
		begin
			live_cnt = live_cnt + life_pkg::row_pop_t'(rows.middle[c]);
		end

		a_live_range: assert (live_cnt <= `GRID_COLS)
			else $error("row count too large: %0d", live_cnt);
	end

	assign rows.next_row = next_cells;
	assign rows.live = live_cnt;

endmodule

`default_nettype wire

//--- rtl/population_counter.sv
`default_nettype none

`include "life_params.svh"

module population_counter (
	row_if.count rows [0:`GRID_ROWS-1],
	output life_pkg::pop_t population
);

	life_pkg::row_pop_t row_live [`GRID_ROWS];
	life_pkg::pop_t total;

	for (genvar r = 0; r < `GRID_ROWS; r++)
	begin : g_rows
		assign row_live[r] = rows[r].live;
	end

	// running sum of the row counts
	always_comb
	begin
		total = '0;
		for (int r = 0; r < `GRID_ROWS; r++)
		begin
			total = total + life_pkg::pop_t'(row_live[r]);
		end

		a_pop_range: assert (total <= `GRID_ROWS * `GRID_COLS)
			else $error("population too large: %0d", total);
	end

	assign population = total;

endmodule

`default_nettype wire

//--- rtl/life_top.sv
`default_nettype none

`include "life_params.svh"

module life_top (
	input wire logic clock,
	input wire logic resetn,

	// single cycle strobes
	input wire logic step,
	input wire logic edit,
	input wire logic save,
	input wire logic restore,

	// edit coordinate
	input wire life_pkg::col_idx_t x,
	input wire life_pkg::row_idx_t y,

	output life_pkg::board_t board,
	output life_pkg::gen_t generation,
	output life_pkg::pop_t population
);

	row_if rows [0:`GRID_ROWS-1] ();

	board_store u_store (
		.clock      (clock),
		.resetn     (resetn),
		.step       (step),
		.edit       (edit),
		.save       (save),
		.restore    (restore),
		.x          (x),
		.y          (y),
		.rows       (rows),
		.board      (board),
		.generation (generation)
	);

	// one rule per row, all combinational
	for (genvar r = 0; r < `GRID_ROWS; r++)
	begin : g_rule
		row_rule u_rule (
			.rows (rows[r])
		);
	end

	population_counter u_count (
		.rows       (rows),
		.population (population)
	);

endmodule

`default_nettype wire

//--- dv/life_tb.sv
`default_nettype none

`include "life_params.svh"

module life_tb;

	localparam int COLS = `GRID_COLS;
	localparam int ROWS = `GRID_ROWS;
	localparam int N_RAND = 40;

	typedef enum logic [2:0] {OP_STEP, OP_EDIT, OP_SAVE, OP_RESTORE, OP_STEP_EDIT} op_t;

	typedef struct {
		op_t op;
		life_pkg::col_idx_t x;
		life_pkg::row_idx_t y;
		life_pkg::pop_t pop;
		life_pkg::gen_t gen;
	} entry_t;

	logic clock;
	logic resetn;
	logic step;
	logic edit;
	logic save;
	logic restore;
	life_pkg::col_idx_t x;
	life_pkg::row_idx_t y;
	life_pkg::board_t board;
	life_pkg::gen_t generation;
	life_pkg::pop_t population;

	entry_t ops_q [$];
	life_pkg::board_t model_board;
	life_pkg::board_t model_saved;
	int model_gen;
	int cycles = 0;
	int limit = 1000000;      // replaced once the table is built

	life_top uut (
		.clock      (clock),
		.resetn     (resetn),
		.step       (step),
		.edit       (edit),
		.save       (save),
		.restore    (restore),
		.x          (x),
		.y          (y),
		.board      (board),
		.generation (generation),
		.population (population)
	);

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock)
	begin
		cycles <= cycles + 1;
		if (cycles > limit)
		begin
			$display("timeout: run still busy after %0d cycles", limit);
			$display("sim failed");
			$fatal(1, "timeout");
		end
	end

	task automatic add_entry(input op_t op, input int ex, input int ey, input int pop, input int gen);
		entry_t e;
		e.op = op;
		e.x = life_pkg::col_idx_t'(ex);
		e.y = life_pkg::row_idx_t'(ey);
		e.pop = life_pkg::pop_t'(pop);
		e.gen = life_pkg::gen_t'(gen);
		ops_q.push_back(e);
	endtask

	// dead outside the board
	function automatic bit alive(input life_pkg::board_t b, input int r, input int c);
		if (r < 0 || r >= ROWS || c < 0 || c >= COLS)
			return 1'b0;
		return b[r*COLS + c];
	endfunction

	function automatic life_pkg::board_t evolve(input life_pkg::board_t b);
		life_pkg::board_t n;
		int cnt;
		n = '0;
		for (int r = 0; r < ROWS; r++)
		begin
			for (int c = 0; c < COLS; c++)
			begin
				cnt = 0;
				for (int dr = -1; dr <= 1; dr++)
				begin
					for (int dc = -1; dc <= 1; dc++)
					begin
						if ((dr != 0 || dc != 0) && alive(b, r + dr, c + dc))
							cnt++;
					end
				end
				n[r*COLS + c] = (cnt == 3) || (cnt == 2 && b[r*COLS + c]);
			end
		end
		return n;
	endfunction

	task automatic model_apply(input op_t op, input int ex, input int ey);
		case (op)
			OP_RESTORE: model_board = model_saved;
			OP_STEP, OP_STEP_EDIT:
			begin
				model_board = evolve(model_board);     // step wins over edit
				model_gen = (model_gen + 1) % `GEN_MODULUS;
			end
			OP_EDIT:
			begin
				if (ex < COLS && ey < ROWS)
					model_board[ey*COLS + ex] = ~model_board[ey*COLS + ex];
			end
			OP_SAVE: model_saved = model_board;
			default: ;
		endcase
	endtask

	// called 1 unit after an edge, returns 1 unit after the next one
	task automatic run_op(input op_t op, input life_pkg::col_idx_t ex, input life_pkg::row_idx_t ey);
		x = ex;
		y = ey;
		step = (op == OP_STEP || op == OP_STEP_EDIT);
		edit = (op == OP_EDIT || op == OP_STEP_EDIT);
		save = (op == OP_SAVE);
		restore = (op == OP_RESTORE);
		@(posedge clock);
		#1;
		step = 1'b0;
		edit = 1'b0;
		save = 1'b0;
		restore = 1'b0;
		model_apply(op, int'(ex), int'(ey));
	endtask

	task automatic check_board(input life_pkg::board_t exp, input life_pkg::board_t act);
		if (act !== exp)
		begin
			$display("[ERROR] %0t board expected %h actual %h", $time, exp, act);
			$display("sim failed");
			$fatal(1, "board mismatch");
		end
	endtask

	task automatic check_population(input life_pkg::pop_t exp, input life_pkg::pop_t act);
		if (act !== exp)
		begin
			$display("[ERROR] %0t population expected %0d actual %0d", $time, exp, act);
			$display("sim failed");
			$fatal(1, "population mismatch");
		end
	endtask

	task automatic check_generation(input life_pkg::gen_t exp, input life_pkg::gen_t act);
		if (act !== exp)
		begin
			$display("[ERROR] %0t generation expected %0d actual %0d", $time, exp, act);
			$display("sim failed");
			$fatal(1, "generation mismatch");
		end
	endtask

	task automatic compare_outputs(input life_pkg::pop_t exp_pop, input life_pkg::gen_t exp_gen);
		check_board(model_board, board);
		check_population(exp_pop, population);
		check_generation(exp_gen, generation);
	endtask

	task automatic build_table();
		add_entry(OP_RESTORE, 0, 0, 0, 0);     // saved board is empty after reset
		add_entry(OP_EDIT, 10, 10, 1, 0);      // blinker
		add_entry(OP_EDIT, 11, 10, 2, 0);
		add_entry(OP_EDIT, 12, 10, 3, 0);
		add_entry(OP_EDIT, 40, 5, 3, 0);       // off the board
		add_entry(OP_EDIT, 5, 30, 3, 0);
		add_entry(OP_EDIT, 20, 20, 4, 0);
		add_entry(OP_EDIT, 20, 20, 3, 0);
		add_entry(OP_STEP, 0, 0, 3, 1);
		add_entry(OP_STEP, 0, 0, 3, 2);
		add_entry(OP_EDIT, 30, 2, 4, 2);       // lone cell, gone after one step
		add_entry(OP_STEP, 0, 0, 3, 3);
		add_entry(OP_EDIT, 2, 20, 4, 3);
		add_entry(OP_EDIT, 3, 20, 5, 3);
		add_entry(OP_EDIT, 2, 21, 6, 3);
		add_entry(OP_EDIT, 3, 21, 7, 3);
		add_entry(OP_STEP, 0, 0, 7, 4);
		add_entry(OP_EDIT, 38, 28, 8, 4);      // block in the bottom-right corner
		add_entry(OP_EDIT, 39, 28, 9, 4);
		add_entry(OP_EDIT, 38, 29, 10, 4);
		add_entry(OP_EDIT, 39, 29, 11, 4);
		add_entry(OP_STEP, 0, 0, 11, 5);
		add_entry(OP_SAVE, 0, 0, 11, 5);
		add_entry(OP_EDIT, 21, 1, 12, 5);      // glider
		add_entry(OP_EDIT, 22, 2, 13, 5);
		add_entry(OP_EDIT, 20, 3, 14, 5);
		add_entry(OP_EDIT, 21, 3, 15, 5);
		add_entry(OP_EDIT, 22, 3, 16, 5);
		for (int k = 6; k <= 9; k++)
			add_entry(OP_STEP, 0, 0, 16, k);
		add_entry(OP_EDIT, 0, 0, 17, 9);
		add_entry(OP_RESTORE, 0, 0, 11, 9);
		add_entry(OP_STEP_EDIT, 0, 0, 11, 10);
		add_entry(OP_SAVE, 0, 0, 11, 10);
		// full lap of the counter, through 99 -> 0
		for (int k = 1; k <= 100; k++)
			add_entry(OP_STEP, 0, 0, 11, (10 + k) % `GEN_MODULUS);
	endtask

	initial
	begin
		life_pkg::col_idx_t rx;
		life_pkg::row_idx_t ry;
		void'($urandom(32'h2c54));
		resetn = 1'b0;
		step = 1'b0;
		edit = 1'b0;
		save = 1'b0;
		restore = 1'b0;
		x = '0;
		y = '0;
		model_board = '0;
		model_saved = '0;
		model_gen = 0;
		build_table();
		limit = 2 * 16 + (ops_q.size() + 1) * 2 + N_RAND * 2 + 50;

		repeat (16) @(posedge clock);
		#1;
		resetn = 1'b1;
		compare_outputs('0, '0);

		foreach (ops_q[i])
		begin
			run_op(ops_q[i].op, ops_q[i].x, ops_q[i].y);
			compare_outputs(ops_q[i].pop, ops_q[i].gen);
		end

		// some coordinates fall off the board on purpose
		for (int i = 0; i < N_RAND; i++)
		begin
			rx = life_pkg::col_idx_t'($urandom_range(0, 41));
			ry = life_pkg::row_idx_t'($urandom_range(0, 31));
			run_op(OP_EDIT, rx, ry);
			compare_outputs(life_pkg::pop_t'($countones(model_board)), life_pkg::gen_t'(model_gen));
			run_op(OP_STEP, '0, '0);
			compare_outputs(life_pkg::pop_t'($countones(model_board)), life_pkg::gen_t'(model_gen));
		end

		// saved board holds a pattern here, reset has to clear it
		resetn = 1'b0;
		repeat (16) @(posedge clock);
		#1;
		resetn = 1'b1;
		model_board = '0;
		model_saved = '0;
		model_gen = 0;
		compare_outputs('0, '0);
		run_op(OP_RESTORE, '0, '0);
		compare_outputs('0, '0);

		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- life.f
+incdir+rtl
rtl/life_pkg.sv
rtl/row_if.sv
rtl/board_store.sv
rtl/row_rule.sv
rtl/population_counter.sv
rtl/life_top.sv
dv/life_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = life_tb
FILELIST = life.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

# a $fatal in the testbench gives a non-zero exit status
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
